//--- rvExecCore.f
+incdir+verification
hdl/rvIsaPkg.sv
hdl/rvExecPkg.sv
hdl/rvRegFile.sv
hdl/rvDecodeStage.sv
hdl/rvExecuteStage.sv
hdl/rvExecCore.sv
verification/rvExecCoreTb.sv

//--- verification/rvRefModel.svh
// assumes xLen 64; included inside the testbench module body, stimulus only reaches x0 to x7
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

localparam int kindR       = 0;
localparam int kindI       = 1;
localparam int kindLui     = 2;
localparam int kindAuipc   = 3;
localparam int kindJal     = 4;
localparam int kindJalr    = 5;
localparam int kindBranch  = 6;
localparam int kindIllegal = 7;
localparam int kindHalt    = 8;

typedef struct packed {
    logic [63:0] pc;
    logic [63:0] nextPc;
    logic        rdWrite;
    logic [4:0]  rd;
    logic [63:0] data;
    logic        illegal;
    logic        halt;
    logic [31:0] issueEdge;
} retireRec;

// architectural registers in program order
logic [63:0] modelRegs [32];
logic [15:0] lfsrState;

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
        lfsrState = lfsrNext(lfsrState);
        v = {v[30:0], lfsrState[0]};
    end
    return v;
endfunction

function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvIsaPkg::opBranch};
endfunction

function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvIsaPkg::opJal};
endfunction

function automatic logic [63:0] aluRef(input logic [2:0] f3, input logic alt,
        input logic [63:0] a, input logic [63:0] b);
    logic [63:0] r;
    case (f3)
        3'd0: r = alt ? a - b : a + b;
        3'd1: r = a << b[5:0];
        3'd2: r = {63'b0, $signed(a) < $signed(b)};
        3'd3: r = {63'b0, a < b};
        3'd4: r = a ^ b;
        3'd5: begin
            if (alt) begin
                r = $signed(a) >>> b[5:0];
            end else begin
                r = a >> b[5:0];
            end
        end
        3'd6: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

function automatic logic branchTaken(input logic [2:0] f3, input logic [63:0] a,
        input logic [63:0] b);
    case (f3)
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return $signed(a) < $signed(b);
        3'd5: return $signed(a) >= $signed(b);
        3'd6: return a < b;
        default: return a >= b;
    endcase
endfunction

// expected retire record; updates the register model as a side effect
function automatic retireRec refExecute(input int kind, input logic [2:0] f3, input logic alt,
        input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
        input logic [63:0] imm, input logic [63:0] pc);
    retireRec    r;
    logic [63:0] a;
    logic [63:0] b;
    logic        writes;
    a        = modelRegs[rs1];
    b        = modelRegs[rs2];
    r        = '0;
    r.pc     = pc;
    r.nextPc = pc + 64'd4;
    writes   = 1'b1;
    case (kind)
        kindR:     r.data = aluRef(f3, alt, a, b);
        kindI:     r.data = aluRef(f3, alt, a, imm);
        kindLui:   r.data = imm;
        kindAuipc: r.data = pc + imm;
        kindJal: begin
            r.data   = pc + 64'd4;
            r.nextPc = pc + imm;
        end
        kindJalr: begin
            r.data   = pc + 64'd4;
            r.nextPc = (a + imm) & ~64'd1;
        end
        kindBranch: begin
            writes = 1'b0;
            if (branchTaken(f3, a, b)) begin
                r.nextPc = pc + imm;
            end
        end
        kindHalt: begin
            writes = 1'b0;
            r.halt = 1'b1;
        end
        default: begin
            writes    = 1'b0;
            r.illegal = 1'b1;
        end
    endcase
    r.rdWrite = writes && (rd != 5'd0);
    r.rd      = r.rdWrite ? rd : 5'd0;
    if (r.rdWrite) begin
        modelRegs[rd] = r.data;
    end
    return r;
endfunction

`endif

//--- verification/rvExecCoreTb.sv
// runs the core at xLen 64 with random traffic on x0 to x7; one idle cycle in four on average
`timescale 1ns/1ps
`default_nettype none

module rvExecCoreTb;

    localparam int instCount  = 600;
    localparam int cycleLimit = 10 + 2 * instCount + 20;

    `include "rvRefModel.svh"

    logic        clk;
    logic        arstN;
    logic        instValid;
    logic [31:0] inst;
    logic [63:0] pc;
    logic        retireValid;
    logic [63:0] retirePc;
    logic [63:0] retireNextPc;
    logic        retireRdWrite;
    logic [4:0]  retireRd;
    logic [63:0] retireData;
    logic        retireIllegal;
    logic        retireHalt;

    int       cycleCount;
    int       valueErrors;
    int       protocolErrors;
    retireRec expQ [$];
    retireRec expRec;

    rvExecCore #(.xLen(64)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic reportValue(input string name, input logic [63:0] got, input logic [63:0] want);
        $display("Error %s: got 0x%h, expected 0x%h at cycle %0d", name, got, want, cycleCount);
        valueErrors++;
    endtask

    // picks one instruction, records its expected retirement and drives it
    task automatic issueRandom();
        logic [31:0] r;
        logic [31:0] sel;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [63:0] imm;
        logic [63:0] pcVal;
        logic [31:0] word;
        int          kind;
        retireRec    rec;
        sel   = randBits(4);
        r     = randBits(9);
        rd    = {2'b00, r[2:0]};
        rs1   = {2'b00, r[5:3]};
        rs2   = {2'b00, r[8:6]};
        f3    = 3'(randBits(3));
        r     = randBits(24);
        pcVal = {38'b0, r[23:0], 2'b00};
        r     = randBits(20);
        alt   = 1'b0;
        imm   = '0;
        kind  = kindIllegal;
        case (sel)
            0, 1: begin
                kind = kindR;
                alt  = (f3 == 3'd0 || f3 == 3'd5) ? r[0] : 1'b0;
                word = {(alt ? rvIsaPkg::f7Alt : rvIsaPkg::f7Base), rs2, rs1, f3, rd,
                        rvIsaPkg::opOp};
            end
            2, 3, 15: begin
                kind = kindI;
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    // 6-bit shamt, bit 10 marks srai
                    alt = (f3 == 3'd5) && r[6];
                    r   = {20'b0, 1'b0, alt, 4'b0, r[5:0]};
                end
                imm  = {{52{r[11]}}, r[11:0]};
                word = {r[11:0], rs1, f3, rd, rvIsaPkg::opOpImm};
            end
            4, 5: begin
                kind = (sel == 4) ? kindLui : kindAuipc;
                imm  = {{32{r[19]}}, r[19:0], 12'b0};
                word = {r[19:0], rd, ((sel == 4) ? rvIsaPkg::opLui : rvIsaPkg::opAuipc)};
            end
            6: begin
                kind = kindJal;
                imm  = {{43{r[19]}}, r[19:0], 1'b0};
                word = encJ({r[19:0], 1'b0}, rd);
            end
            7: begin
                kind = kindJalr;
                imm  = {{52{r[11]}}, r[11:0]};
                word = {r[11:0], rs1, 3'b000, rd, rvIsaPkg::opJalr};
            end
            8, 9: begin
                kind = kindBranch;
                // 2 and 3 are not branches, fold them onto ltu and geu
                if (f3[2:1] == 2'b01) begin
                    f3 = f3 | 3'b100;
                end
                imm  = {{51{r[11]}}, r[11:0], 1'b0};
                word = encB({r[11:0], 1'b0}, rs2, rs1, f3);
            end
            10: word = {r[11:0], rs1, 3'b011, rd, 7'b0000011};
            11: word = {r[11:5], rs2, rs1, 3'b011, r[4:0], 7'b0100011};
            12: word = {12'h300, rs1, 3'b001, rd, rvIsaPkg::opSystem};
            13: word = {7'b0000001, rs2, rs1, f3, rd, rvIsaPkg::opOp};
            default: begin
                kind = kindHalt;
                word = rvIsaPkg::ebreakWord;
            end
        endcase
        rec = refExecute(kind, f3, alt, rd, rs1, rs2, imm, pcVal);
        rec.issueEdge = cycleCount;
        expQ.push_back(rec);
        instValid = 1'b1;
        inst      = word;
        pc        = pcVal;
    endtask

    always @(negedge clk) begin
        if (retireValid) begin
            if (expQ.size() == 0) begin
                $display("retireValid is high at cycle %0d with nothing outstanding", cycleCount);
                protocolErrors++;
            end else begin
                expRec = expQ.pop_front();
                if (cycleCount != expRec.issueEdge + 2) begin
                    $display("cycle %0d retirement is not 2 edges after its issue at edge %0d",
                             cycleCount, expRec.issueEdge);
                    protocolErrors++;
                end
                if (retirePc !== expRec.pc) begin
                    reportValue("retirePc", retirePc, expRec.pc);
                end
                if (retireNextPc !== expRec.nextPc) begin
                    reportValue("retireNextPc", retireNextPc, expRec.nextPc);
                end
                if (retireRdWrite !== expRec.rdWrite) begin
                    reportValue("retireRdWrite", 64'(retireRdWrite), 64'(expRec.rdWrite));
                end
                if (retireRd !== expRec.rd) begin
                    reportValue("retireRd", 64'(retireRd), 64'(expRec.rd));
                end
                if (expRec.rdWrite && retireData !== expRec.data) begin
                    reportValue("retireData", retireData, expRec.data);
                end
                if (retireIllegal !== expRec.illegal) begin
                    reportValue("retireIllegal", 64'(retireIllegal), 64'(expRec.illegal));
                end
                if (retireHalt !== expRec.halt) begin
                    reportValue("retireHalt", 64'(retireHalt), 64'(expRec.halt));
                end
            end
        end else if (expQ.size() != 0 && expQ[0].issueEdge + 2 <= cycleCount) begin
            $display("no retirement 2 edges after the issue at edge %0d", expQ[0].issueEdge);
            protocolErrors++;
            void'(expQ.pop_front());
        end
    end

    always @(posedge clk) begin
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("errors: %0d value, %0d protocol", valueErrors, protocolErrors);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        int n;
        arstN          = 1'b0;
        instValid      = 1'b0;
        inst           = '0;
        pc             = '0;
        cycleCount     = 0;
        valueErrors    = 0;
        protocolErrors = 0;
        lfsrState      = 16'd80;
        for (n = 0; n < 32; n++) begin
            modelRegs[n] = '0;
        end
        repeat (10) @(posedge clk);
        #1 arstN = 1'b1;
        for (n = 0; n < instCount; n++) begin
            if (randBits(2) == 0) begin
                instValid = 1'b0;
                @(posedge clk);
                #1;
            end
            issueRandom();
            @(posedge clk);
            #1;
        end
        instValid = 1'b0;
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        // catch any stray retirement
        repeat (3) @(negedge clk);
        $display("errors: %0d value, %0d protocol", valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/rvExecCore.sv
// two-stage core with external pc and no back-pressure; retire follows issue by exactly 2 edges
`timescale 1ns/1ps
`default_nettype none

module rvExecCore #(
    parameter int xLen = 64
) (
    input  wire logic                              clk,
    input  wire logic                              arstN,
    input  wire logic                              instValid,
    input  wire logic [rvIsaPkg::instWidth-1:0]    inst,
    input  wire logic [xLen-1:0]                   pc,
    output logic                                   retireValid,
    output logic      [xLen-1:0]                   retirePc,
    output logic      [xLen-1:0]                   retireNextPc,
    output logic                                   retireRdWrite,
    output logic      [rvIsaPkg::regAddrWidth-1:0] retireRd,
    output logic      [xLen-1:0]                   retireData,
    output logic                                   retireIllegal,
    output logic                                   retireHalt
);

    logic [rvIsaPkg::regAddrWidth-1:0] rs1Addr;
    logic [rvIsaPkg::regAddrWidth-1:0] rs2Addr;
    logic [xLen-1:0]                   rs1Data;
    logic [xLen-1:0]                   rs2Data;

    // decode to execute
    logic                              decValid;
    logic [xLen-1:0]                   decPc;
    logic [rvIsaPkg::regAddrWidth-1:0] decRs1;
    logic [rvIsaPkg::regAddrWidth-1:0] decRs2;
    logic [xLen-1:0]                   decRs1Data;
    logic [xLen-1:0]                   decRs2Data;
    logic [xLen-1:0]                   decImm;
    rvExecPkg::aluOp                   decAluOp;
    rvExecPkg::operandASel             decASel;
    rvExecPkg::operandBSel             decBSel;
    rvExecPkg::branchCond              decBranch;
    rvExecPkg::wbSource                decWbSrc;
    logic [rvIsaPkg::regAddrWidth-1:0] decRd;
    logic                              decIllegal;
    logic                              decHalt;

    rvDecodeStage #(.xLen(xLen)) uDecode (.*);

    rvExecuteStage #(.xLen(xLen)) uExecute (.*);

    // retire record doubles as the write port
    rvRegFile #(.xLen(xLen)) uRegFile (
        .clk,
        .arstN,
        .rs1Addr,
        .rs2Addr,
        .rs1Data,
        .rs2Data,
        .wrEn   (retireRdWrite),
        .wrAddr (retireRd),
        .wrData (retireData)
    );

endmodule

`default_nettype wire

//--- hdl/rvExecuteStage.sv
// one-cycle execute; forwards only from its own retire register, so no stall is ever needed
`timescale 1ns/1ps
`default_nettype none

module rvExecuteStage #(
    parameter int xLen = 64
) (
    input  wire logic                              clk,
    input  wire logic                              arstN,
    input  wire logic                              decValid,
    input  wire logic [xLen-1:0]                   decPc,
    input  wire logic [rvIsaPkg::regAddrWidth-1:0] decRs1,
    input  wire logic [rvIsaPkg::regAddrWidth-1:0] decRs2,
    input  wire logic [xLen-1:0]                   decRs1Data,
    input  wire logic [xLen-1:0]                   decRs2Data,
    input  wire logic [xLen-1:0]                   decImm,
    input  wire rvExecPkg::aluOp                   decAluOp,
    input  wire rvExecPkg::operandASel             decASel,
    input  wire rvExecPkg::operandBSel             decBSel,
    input  wire rvExecPkg::branchCond              decBranch,
    input  wire rvExecPkg::wbSource                decWbSrc,
    input  wire logic [rvIsaPkg::regAddrWidth-1:0] decRd,
    input  wire logic                              decIllegal,
    input  wire logic                              decHalt,
    output logic                                   retireValid,
    output logic      [xLen-1:0]                   retirePc,
    output logic      [xLen-1:0]                   retireNextPc,
    output logic                                   retireRdWrite,
    output logic      [rvIsaPkg::regAddrWidth-1:0] retireRd,
    output logic      [xLen-1:0]                   retireData,
    output logic                                   retireIllegal,
    output logic                                   retireHalt
);

    localparam int shamtWidth = (xLen == 64) ? 6 : 5;

    logic [xLen-1:0]       rs1Val;
    logic [xLen-1:0]       rs2Val;
    logic [xLen-1:0]       opA;
    logic [xLen-1:0]       opB;
    logic [shamtWidth-1:0] shamt;
    logic [xLen-1:0]       aluResult;
    logic [xLen-1:0]       pcPlus4;
    logic [xLen-1:0]       nextPc;
    logic [xLen-1:0]       wbData;
    logic                  taken;

    // retireRdWrite is never set for x0
    assign rs1Val = (retireRdWrite && retireRd == decRs1) ? retireData : decRs1Data;
    assign rs2Val = (retireRdWrite && retireRd == decRs2) ? retireData : decRs2Data;

    always_comb begin
        case (decASel)
            rvExecPkg::aSelRs1: opA = rs1Val;
            rvExecPkg::aSelPc:  opA = decPc;
            default:            opA = '0;
        endcase
    end

    assign opB   = (decBSel == rvExecPkg::bSelImm) ? decImm : rs2Val;
    assign shamt = opB[shamtWidth-1:0];

    always_comb begin
        case (decAluOp)
            rvExecPkg::aluSub:  aluResult = opA - opB;
            rvExecPkg::aluSll:  aluResult = opA << shamt;
            rvExecPkg::aluSlt:  aluResult = xLen'($signed(opA) < $signed(opB));
            rvExecPkg::aluSltu: aluResult = xLen'(opA < opB);
            rvExecPkg::aluXor:  aluResult = opA ^ opB;
            rvExecPkg::aluSrl:  aluResult = opA >> shamt;
            rvExecPkg::aluSra:  aluResult = $signed(opA) >>> shamt;
            rvExecPkg::aluOr:   aluResult = opA | opB;
            rvExecPkg::aluAnd:  aluResult = opA & opB;
            default:            aluResult = opA + opB;
        endcase
    end

    // compares use the forwarded sources
    always_comb begin
        case (decBranch)
            rvExecPkg::brAlways: taken = 1'b1;
            rvExecPkg::brEq:     taken = rs1Val == rs2Val;
            rvExecPkg::brNe:     taken = rs1Val != rs2Val;
            rvExecPkg::brLt:     taken = $signed(rs1Val) < $signed(rs2Val);
            rvExecPkg::brGe:     taken = $signed(rs1Val) >= $signed(rs2Val);
            rvExecPkg::brLtu:    taken = rs1Val < rs2Val;
            rvExecPkg::brGeu:    taken = rs1Val >= rs2Val;
            default:             taken = 1'b0;
        endcase
    end

    assign pcPlus4 = decPc + xLen'(4);

    // alu already holds pc+imm or rs1+imm; clearing bit 0 only matters for jalr
    assign nextPc = taken ? {aluResult[xLen-1:1], 1'b0} : pcPlus4;

    always_comb begin
        case (decWbSrc)
            rvExecPkg::wbAlu:  wbData = aluResult;
            rvExecPkg::wbLink: wbData = pcPlus4;
            default:           wbData = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            retireValid   <= 1'b0;
            retirePc      <= '0;
            retireNextPc  <= '0;
            retireRdWrite <= 1'b0;
            retireRd      <= '0;
            retireData    <= '0;
            retireIllegal <= 1'b0;
            retireHalt    <= 1'b0;
        end else begin
            retireValid   <= decValid;
            retireRdWrite <= decValid && (decRd != '0);
            if (decValid) begin
                retirePc      <= decPc;
                retireNextPc  <= nextPc;
                retireRd      <= decRd;
                retireData    <= wbData;
                retireIllegal <= decIllegal;
                retireHalt    <= decHalt;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/rvDecodeStage.sv
// base integer subset only; loads, stores, CSR, fence, M and W ops are flagged illegal
`timescale 1ns/1ps
`default_nettype none

module rvDecodeStage #(
    parameter int xLen = 64
) (
    input  wire logic                              clk,
    input  wire logic                              arstN,
    input  wire logic                              instValid,
    input  wire logic [rvIsaPkg::instWidth-1:0]    inst,
    input  wire logic [xLen-1:0]                   pc,
    output logic      [rvIsaPkg::regAddrWidth-1:0] rs1Addr,
    output logic      [rvIsaPkg::regAddrWidth-1:0] rs2Addr,
    input  wire logic [xLen-1:0]                   rs1Data,
    input  wire logic [xLen-1:0]                   rs2Data,
    output logic                                   decValid,
    output logic      [xLen-1:0]                   decPc,
    output logic      [rvIsaPkg::regAddrWidth-1:0] decRs1,
    output logic      [rvIsaPkg::regAddrWidth-1:0] decRs2,
    output logic      [xLen-1:0]                   decRs1Data,
    output logic      [xLen-1:0]                   decRs2Data,
    output logic      [xLen-1:0]                   decImm,
    output rvExecPkg::aluOp                        decAluOp,
    output rvExecPkg::operandASel                  decASel,
    output rvExecPkg::operandBSel                  decBSel,
    output rvExecPkg::branchCond                   decBranch,
    output rvExecPkg::wbSource                     decWbSrc,
    output logic      [rvIsaPkg::regAddrWidth-1:0] decRd,
    output logic                                   decIllegal,
    output logic                                   decHalt
);

    localparam int shamtWidth = (xLen == 64) ? 6 : 5;

    logic [6:0]                        opcode;
    logic [2:0]                        funct3;
    logic [6:0]                        funct7;
    logic [rvIsaPkg::regAddrWidth-1:0] rdField;
    logic                              shiftBase;
    logic                              shiftAlt;
    logic [xLen-1:0]                   imm;
    rvIsaPkg::instFormat               fmt;
    rvExecPkg::aluOp                   aluOpC;
    rvExecPkg::operandASel             aSelC;
    rvExecPkg::operandBSel             bSelC;
    rvExecPkg::branchCond              branchC;
    rvExecPkg::wbSource                wbSrcC;
    logic                              illegalC;
    logic                              haltC;

    assign opcode  = inst[rvIsaPkg::opcodeLsb +: 7];
    assign funct3  = inst[rvIsaPkg::funct3Lsb +: 3];
    assign funct7  = inst[rvIsaPkg::funct7Lsb +: 7];
    assign rdField = inst[rvIsaPkg::rdLsb +: rvIsaPkg::regAddrWidth];
    assign rs1Addr = inst[rvIsaPkg::rs1Lsb +: rvIsaPkg::regAddrWidth];
    assign rs2Addr = inst[rvIsaPkg::rs2Lsb +: rvIsaPkg::regAddrWidth];

    // shift immediates: funct7 minus the shamt bits that reach into it
    assign shiftBase = inst[31:20+shamtWidth] == rvIsaPkg::f7Base[6:shamtWidth-5];
    assign shiftAlt  = inst[31:20+shamtWidth] == rvIsaPkg::f7Alt[6:shamtWidth-5];

    function automatic rvExecPkg::aluOp aluFromF3(input logic [2:0] f3, input logic alt);
        rvExecPkg::aluOp op;
        case (f3)
            rvIsaPkg::f3AddSub: op = alt ? rvExecPkg::aluSub : rvExecPkg::aluAdd;
            rvIsaPkg::f3Sll:    op = rvExecPkg::aluSll;
            rvIsaPkg::f3Slt:    op = rvExecPkg::aluSlt;
            rvIsaPkg::f3Sltu:   op = rvExecPkg::aluSltu;
            rvIsaPkg::f3Xor:    op = rvExecPkg::aluXor;
            rvIsaPkg::f3Srl:    op = alt ? rvExecPkg::aluSra : rvExecPkg::aluSrl;
            rvIsaPkg::f3Or:     op = rvExecPkg::aluOr;
            default:            op = rvExecPkg::aluAnd;
        endcase
        return op;
    endfunction

    always_comb begin
        fmt      = rvIsaPkg::fmtNone;
        aluOpC   = rvExecPkg::aluAdd;
        aSelC    = rvExecPkg::aSelRs1;
        bSelC    = rvExecPkg::bSelRs2;
        branchC  = rvExecPkg::brNever;
        wbSrcC   = rvExecPkg::wbNone;
        illegalC = 1'b1;
        haltC    = 1'b0;
        case (opcode)
            rvIsaPkg::opOp: begin
                // M extension (funct7 0000001) falls through as illegal
                if (funct7 == rvIsaPkg::f7Base || (funct7 == rvIsaPkg::f7Alt &&
                        (funct3 == rvIsaPkg::f3AddSub || funct3 == rvIsaPkg::f3Srl))) begin
                    fmt      = rvIsaPkg::fmtR;
                    aluOpC   = aluFromF3(funct3, funct7 == rvIsaPkg::f7Alt);
                    wbSrcC   = rvExecPkg::wbAlu;
                    illegalC = 1'b0;
                end
            end
            rvIsaPkg::opOpImm: begin
                if ((funct3 != rvIsaPkg::f3Sll && funct3 != rvIsaPkg::f3Srl) || shiftBase ||
                        (funct3 == rvIsaPkg::f3Srl && shiftAlt)) begin
                    fmt      = rvIsaPkg::fmtI;
                    aluOpC   = aluFromF3(funct3, funct3 == rvIsaPkg::f3Srl && shiftAlt);
                    bSelC    = rvExecPkg::bSelImm;
                    wbSrcC   = rvExecPkg::wbAlu;
                    illegalC = 1'b0;
                end
            end
            rvIsaPkg::opLui, rvIsaPkg::opAuipc: begin
                fmt      = rvIsaPkg::fmtU;
                aSelC    = (opcode == rvIsaPkg::opLui) ? rvExecPkg::aSelZero : rvExecPkg::aSelPc;
                bSelC    = rvExecPkg::bSelImm;
                wbSrcC   = rvExecPkg::wbAlu;
                illegalC = 1'b0;
            end
            rvIsaPkg::opJal: begin
                fmt      = rvIsaPkg::fmtJ;
                aSelC    = rvExecPkg::aSelPc;
                bSelC    = rvExecPkg::bSelImm;
                branchC  = rvExecPkg::brAlways;
                wbSrcC   = rvExecPkg::wbLink;
                illegalC = 1'b0;
            end
            rvIsaPkg::opJalr: begin
                if (funct3 == 3'b000) begin
                    fmt      = rvIsaPkg::fmtI;
                    bSelC    = rvExecPkg::bSelImm;
                    branchC  = rvExecPkg::brAlways;
                    wbSrcC   = rvExecPkg::wbLink;
                    illegalC = 1'b0;
                end
            end
            rvIsaPkg::opBranch: begin
                // target pc + imm comes out of the alu
                fmt      = rvIsaPkg::fmtB;
                aSelC    = rvExecPkg::aSelPc;
                bSelC    = rvExecPkg::bSelImm;
                illegalC = 1'b0;
                case (funct3)
                    rvIsaPkg::f3Beq:  branchC = rvExecPkg::brEq;
                    rvIsaPkg::f3Bne:  branchC = rvExecPkg::brNe;
                    rvIsaPkg::f3Blt:  branchC = rvExecPkg::brLt;
                    rvIsaPkg::f3Bge:  branchC = rvExecPkg::brGe;
                    rvIsaPkg::f3Bltu: branchC = rvExecPkg::brLtu;
                    rvIsaPkg::f3Bgeu: branchC = rvExecPkg::brGeu;
                    default: begin
                        fmt      = rvIsaPkg::fmtNone;
                        illegalC = 1'b1;
                    end
                endcase
            end
            rvIsaPkg::opSystem: begin
                // ebreak only, ecall and csr ops stay illegal
                if (inst == rvIsaPkg::ebreakWord) begin
                    haltC    = 1'b1;
                    illegalC = 1'b0;
                end
            end
            default: begin
                illegalC = 1'b1;
            end
        endcase
    end

    always_comb begin
        case (fmt)
            rvIsaPkg::fmtI: imm = xLen'($signed(inst[31:20]));
            rvIsaPkg::fmtB: imm = xLen'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
            rvIsaPkg::fmtU: imm = xLen'($signed({inst[31:12], 12'b0}));
            rvIsaPkg::fmtJ: imm = xLen'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
            default:        imm = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decValid   <= 1'b0;
            decPc      <= '0;
            decRs1     <= '0;
            decRs2     <= '0;
            decRs1Data <= '0;
            decRs2Data <= '0;
            decImm     <= '0;
            decAluOp   <= rvExecPkg::aluAdd;
            decASel    <= rvExecPkg::aSelRs1;
            decBSel    <= rvExecPkg::bSelRs2;
            decBranch  <= rvExecPkg::brNever;
            decWbSrc   <= rvExecPkg::wbNone;
            decRd      <= '0;
            decIllegal <= 1'b0;
            decHalt    <= 1'b0;
        end else begin
            decValid <= instValid;
            if (instValid) begin
                decPc      <= pc;
                decRs1     <= rs1Addr;
                decRs2     <= rs2Addr;
                decRs1Data <= rs1Data;
                decRs2Data <= rs2Data;
                decImm     <= imm;
                decAluOp   <= aluOpC;
                decASel    <= aSelC;
                decBSel    <= bSelC;
                decBranch  <= branchC;
                decWbSrc   <= wbSrcC;
                // rd zero means no write
                decRd      <= (wbSrcC != rvExecPkg::wbNone) ? rdField : '0;
                decIllegal <= illegalC;
                decHalt    <= haltC;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/rvRegFile.sv
// 32 x xLen registers, all cleared by arstN; x0 reads zero and a same-cycle write is bypassed
`timescale 1ns/1ps
`default_nettype none

module rvRegFile #(
    parameter int xLen = 64
) (
    input  wire logic                              clk,
    input  wire logic                              arstN,
    input  wire logic [rvIsaPkg::regAddrWidth-1:0] rs1Addr,
    input  wire logic [rvIsaPkg::regAddrWidth-1:0] rs2Addr,
    output logic      [xLen-1:0]                   rs1Data,
    output logic      [xLen-1:0]                   rs2Data,
    input  wire logic                              wrEn,
    input  wire logic [rvIsaPkg::regAddrWidth-1:0] wrAddr,
    input  wire logic [xLen-1:0]                   wrData
);

    logic [xLen-1:0] regs [32];
    logic            wrLive;

    // x0 is never written
    assign wrLive = wrEn && (wrAddr != '0);

    function automatic logic [xLen-1:0] readPort(input logic [rvIsaPkg::regAddrWidth-1:0] addr);
        logic [xLen-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (wrLive && (wrAddr == addr)) begin
            value = wrData;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    assign rs1Data = readPort(rs1Addr);
    assign rs2Data = readPort(rs2Addr);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rvExecPkg.sv
// internal control codes shared by decode and execute; values carry no ISA meaning
`default_nettype none

package rvExecPkg;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd
    } aluOp;

    // jumps use brAlways, non-branches brNever
    typedef enum logic [2:0] {
        brNever,
        brAlways,
        brEq,
        brNe,
        brLt,
        brGe,
        brLtu,
        brGeu
    } branchCond;

    // link writes pc plus 4
    typedef enum logic [1:0] {
        wbAlu,
        wbLink,
        wbNone
    } wbSource;

    typedef enum logic [1:0] {
        aSelRs1,
        aSelPc,
        aSelZero
    } operandASel;

    typedef enum logic {
        bSelRs2,
        bSelImm
    } operandBSel;

endpackage

`default_nettype wire

//--- hdl/rvIsaPkg.sv
// base integer encodings only; compressed, M, A and CSR opcodes are deliberately not listed
`default_nettype none

package rvIsaPkg;

    localparam int instWidth    = 32;
    localparam int regAddrWidth = 5;

    // field positions inside the instruction word
    localparam int opcodeLsb = 0;
    localparam int rdLsb     = 7;
    localparam int funct3Lsb = 12;
    localparam int rs1Lsb    = 15;
    localparam int rs2Lsb    = 20;
    localparam int funct7Lsb = 25;

    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opSystem = 7'b1110011;

    // alu funct3
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Srl    = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // branch funct3
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // alt selects sub and sra
    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt  = 7'b0100000;

    localparam logic [31:0] ebreakWord = 32'h0010_0073;

    typedef enum logic [2:0] {
        fmtR    = 3'b000,
        fmtI    = 3'b001,
        fmtS    = 3'b010,
        fmtB    = 3'b011,
        fmtU    = 3'b100,
        fmtJ    = 3'b101,
        fmtNone = 3'b111
    } instFormat;

endpackage

`default_nettype wire
